//--- src/isa_pkg.sv
package isa_pkg;

  typedef logic [15:0] word_t;
  typedef logic [2:0]  reg_idx_t;
  typedef logic [4:0]  opcode_t;
  typedef logic [1:0]  func_t;

  localparam int NUM_REGS = 8;

  localparam opcode_t OP_HALT = 5'b00000;
  localparam opcode_t OP_NOP  = 5'b00001;
  localparam opcode_t OP_JAL  = 5'b00110;
  localparam opcode_t OP_ADDI = 5'b01000;
  localparam opcode_t OP_BEQZ = 5'b01100;
  localparam opcode_t OP_BNEZ = 5'b01101;
  localparam opcode_t OP_ST   = 5'b10000;
  localparam opcode_t OP_LD   = 5'b10001;
  localparam opcode_t OP_LBI  = 5'b11000;
  localparam opcode_t OP_ALU  = 5'b11011;

  // subtract is rs minus rt
  localparam func_t FUNC_ADD = 2'b00;
  localparam func_t FUNC_SUB = 2'b01;
  localparam func_t FUNC_XOR = 2'b10;
  localparam func_t FUNC_AND = 2'b11;

  localparam int OPC_HI  = 15;
  localparam int OPC_LO  = 11;
  localparam int RS_HI   = 10;
  localparam int RS_LO   = 8;
  // R-format
  localparam int RT_HI   = 7;
  localparam int RT_LO   = 5;
  localparam int RD_HI   = 4;
  localparam int RD_LO   = 2;
  localparam int FUNC_HI = 1;
  localparam int FUNC_LO = 0;
  // I-format destination and the data register of a store
  localparam int RDI_HI  = 7;
  localparam int RDI_LO  = 5;
  localparam int IMM5_HI = 4;
  localparam int IMM8_HI = 7;

  localparam reg_idx_t LINK_REG = 3'd7;

endpackage

//--- src/pipe_pkg.sv
package pipe_pkg;
  import isa_pkg::*;

  typedef logic [1:0] result_sel_t;

  localparam result_sel_t RES_ALU  = 2'd0;
  localparam result_sel_t RES_IMM  = 2'd1;
  localparam result_sel_t RES_LINK = 2'd2;

  // a return address and a branch target are both relative to the next pc
  localparam word_t PC_STEP = 16'd2;

  // what id_ex holds after reset, a hazard or a flush
  localparam opcode_t     BUBBLE_OPCODE     = OP_NOP;
  localparam reg_idx_t    BUBBLE_RD         = 3'd0;
  localparam result_sel_t BUBBLE_RESULT_SEL = RES_ALU;

endpackage

//--- src/dx_if.sv
interface dx_if import isa_pkg::*, pipe_pkg::*; ();

  logic        nop_d, nop_x;
  logic        halt_d, halt_x;
  logic        err_d, err_x;
  reg_idx_t    rd_d, rd_x;
  logic        reg_write_d, reg_write_x;
  word_t       rs_data_d, rs_data_x;
  word_t       rt_data_d, rt_data_x;
  word_t       imm_d, imm_x;
  word_t       pc_d, pc_x;
  opcode_t     opcode_d, opcode_x;
  func_t       func_d, func_x;
  logic        mem_read_d, mem_read_x;
  logic        mem_write_d, mem_write_x;
  logic        branch_d, branch_x;
  logic        branch_ne_d, branch_ne_x;
  logic        save_pc_d, save_pc_x;
  result_sel_t result_sel_d, result_sel_x;

  // the decoder also looks at the x set to find read-after-write hazards
  modport decode (
    output nop_d, halt_d, err_d, rd_d, reg_write_d, rs_data_d, rt_data_d, imm_d, pc_d,
           opcode_d, func_d, mem_read_d, mem_write_d, branch_d, branch_ne_d, save_pc_d,
           result_sel_d,
    input  nop_x, rd_x, reg_write_x
  );

  modport register (
    input  nop_d, halt_d, err_d, rd_d, reg_write_d, rs_data_d, rt_data_d, imm_d, pc_d,
           opcode_d, func_d, mem_read_d, mem_write_d, branch_d, branch_ne_d, save_pc_d,
           result_sel_d,
    output nop_x, halt_x, err_x, rd_x, reg_write_x, rs_data_x, rt_data_x, imm_x, pc_x,
           opcode_x, func_x, mem_read_x, mem_write_x, branch_x, branch_ne_x, save_pc_x,
           result_sel_x
  );

  modport exec (
    input nop_x, halt_x, err_x, rd_x, reg_write_x, rs_data_x, rt_data_x, imm_x, pc_x,
          opcode_x, func_x, mem_read_x, mem_write_x, branch_x, branch_ne_x, save_pc_x,
          result_sel_x
  );

endinterface

//--- src/decoder.sv
module decoder import isa_pkg::*, pipe_pkg::*; (
  input  word_t    instr,
  input  word_t    pc,
  input  logic     fetch_nop,
  input  logic     stall_m,
  output reg_idx_t ra,
  output reg_idx_t rb,
  input  word_t    ra_data,
  input  word_t    rb_data,
  dx_if.decode     dx,
  output logic     hold
);

  opcode_t opcode;
  word_t   imm5_sext;
  word_t   imm8_sext;
  logic    use_rs;
  logic    use_rt;
  logic    hazard;

  assign opcode = instr[OPC_HI:OPC_LO];

  // rb always addresses bits 7 to 5, which is rt or the store data register
  assign ra = instr[RS_HI:RS_LO];
  assign rb = instr[RT_HI:RT_LO];

  assign imm5_sext = word_t'($signed(instr[IMM5_HI:0]));
  assign imm8_sext = word_t'($signed(instr[IMM8_HI:0]));

  always_comb begin
    dx.nop_d        = fetch_nop;
    dx.halt_d       = 1'b0;
    dx.err_d        = 1'b0;
    dx.rd_d         = instr[RD_HI:RD_LO];
    dx.reg_write_d  = 1'b0;
    dx.rs_data_d    = ra_data;
    dx.rt_data_d    = rb_data;
    dx.imm_d        = imm5_sext;
    dx.pc_d         = pc;
    dx.opcode_d     = opcode;
    dx.func_d       = instr[FUNC_HI:FUNC_LO];
    dx.mem_read_d   = 1'b0;
    dx.mem_write_d  = 1'b0;
    dx.branch_d     = 1'b0;
    dx.branch_ne_d  = 1'b0;
    dx.save_pc_d    = 1'b0;
    dx.result_sel_d = RES_ALU;
    use_rs          = 1'b0;
    use_rt          = 1'b0;

    if (!fetch_nop) begin
      case (opcode)
        OP_NOP: dx.nop_d = 1'b1;
        OP_HALT: dx.halt_d = 1'b1;
        OP_ALU: begin
          dx.reg_write_d = 1'b1;
          use_rs         = 1'b1;
          use_rt         = 1'b1;
        end
        OP_ADDI: begin
          dx.rd_d        = instr[RDI_HI:RDI_LO];
          dx.reg_write_d = 1'b1;
          use_rs         = 1'b1;
        end
        // LBI has no room for rd in bits 7 to 5 so it writes the rs field
        OP_LBI: begin
          dx.rd_d         = instr[RS_HI:RS_LO];
          dx.reg_write_d  = 1'b1;
          dx.imm_d        = imm8_sext;
          dx.result_sel_d = RES_IMM;
        end
        OP_LD: begin
          dx.rd_d        = instr[RDI_HI:RDI_LO];
          dx.reg_write_d = 1'b1;
          dx.mem_read_d  = 1'b1;
          use_rs         = 1'b1;
        end
        OP_ST: begin
          dx.mem_write_d = 1'b1;
          use_rs         = 1'b1;
          use_rt         = 1'b1;
        end
        OP_BEQZ, OP_BNEZ: begin
          dx.branch_d    = 1'b1;
          dx.branch_ne_d = (opcode == OP_BNEZ);
          dx.imm_d       = imm8_sext;
          use_rs         = 1'b1;
        end
        // JAL takes its offset from the same 8-bit field as the branches
        OP_JAL: begin
          dx.rd_d         = LINK_REG;
          dx.reg_write_d  = 1'b1;
          dx.save_pc_d    = 1'b1;
          dx.imm_d        = imm8_sext;
          dx.result_sel_d = RES_LINK;
        end
        default: begin
          dx.err_d = 1'b1;
          dx.nop_d = 1'b1;
        end
      endcase
    end
  end

  // there is no forwarding, so any source written by the instruction in id_ex must wait
  assign hazard = !dx.nop_x && dx.reg_write_x &&
                  ((use_rs && (ra == dx.rd_x)) || (use_rt && (rb == dx.rd_x)));

  assign hold = hazard || stall_m;

endmodule

//--- src/reg_file.sv
module reg_file import isa_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  reg_idx_t ra,
  input  reg_idx_t rb,
  output word_t    ra_data,
  output word_t    rb_data,
  input  logic     wb_en,
  input  reg_idx_t wb_rd,
  input  word_t    wb_data
);

  word_t regs [NUM_REGS];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_en) begin
      regs[wb_rd] <= wb_data;
    end
  end

  // a read of the register being written this cycle sees the new value
  assign ra_data = (wb_en && (wb_rd == ra)) ? wb_data : regs[ra];
  assign rb_data = (wb_en && (wb_rd == rb)) ? wb_data : regs[rb];

endmodule

//--- src/id_ex.sv
module id_ex import pipe_pkg::*; (
  input logic    clk,
  input logic    rst_n,
  dx_if.register dx,
  input logic    stall_m,
  input logic    hazard,
  input logic    flush
);

  logic bubble;

  // flush and hazard both replace the incoming instruction with a bubble
  assign bubble = flush || hazard;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      dx.nop_x        <= 1'b1;
      dx.halt_x       <= 1'b0;
      dx.err_x        <= 1'b0;
      dx.rd_x         <= BUBBLE_RD;
      dx.reg_write_x  <= 1'b0;
      dx.opcode_x     <= BUBBLE_OPCODE;
      dx.mem_read_x   <= 1'b0;
      dx.mem_write_x  <= 1'b0;
      dx.branch_x     <= 1'b0;
      dx.branch_ne_x  <= 1'b0;
      dx.save_pc_x    <= 1'b0;
      dx.result_sel_x <= BUBBLE_RESULT_SEL;
    end else if (!stall_m) begin
      dx.nop_x        <= bubble || dx.nop_d;
      // a halt behind a taken branch must never reach execute
      dx.halt_x       <= !bubble && dx.halt_d;
      dx.err_x        <= !bubble && dx.err_d;
      dx.rd_x         <= bubble ? BUBBLE_RD : dx.rd_d;
      dx.reg_write_x  <= !bubble && dx.reg_write_d;
      dx.opcode_x     <= bubble ? BUBBLE_OPCODE : dx.opcode_d;
      dx.mem_read_x   <= !bubble && dx.mem_read_d;
      dx.mem_write_x  <= !bubble && dx.mem_write_d;
      dx.branch_x     <= !bubble && dx.branch_d;
      dx.branch_ne_x  <= !bubble && dx.branch_ne_d;
      dx.save_pc_x    <= !bubble && dx.save_pc_d;
      dx.result_sel_x <= bubble ? BUBBLE_RESULT_SEL : dx.result_sel_d;
    end
  end

  always_ff @(posedge clk) begin
    if (!stall_m) begin
      dx.rs_data_x <= dx.rs_data_d;
      dx.rt_data_x <= dx.rt_data_d;
      dx.imm_x     <= dx.imm_d;
      dx.pc_x      <= dx.pc_d;
      dx.func_x    <= dx.func_d;
    end
  end

endmodule

//--- src/execute.sv
module execute import isa_pkg::*, pipe_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  dx_if.exec       dx,
  input  logic     stall_m,
  output logic     ex_valid,
  output word_t    ex_result,
  output reg_idx_t ex_rd,
  output logic     ex_reg_write,
  output logic     ex_mem_read,
  output logic     ex_mem_write,
  output word_t    ex_store_data,
  output logic     branch_taken,
  output word_t    branch_target,
  output logic     halt,
  output logic     err
);

  func_t alu_func;
  word_t alu_b;
  word_t alu_out;
  word_t link_pc;
  word_t target;
  word_t result;
  logic  rs_zero;
  logic  take;
  logic  live;

  // the instruction right behind a taken branch is squashed here
  assign live = !dx.nop_x && !branch_taken;

  always_comb begin
    alu_func = FUNC_ADD;
    alu_b    = dx.imm_x;
    if (dx.opcode_x == OP_ALU) begin
      alu_func = dx.func_x;
      alu_b    = dx.rt_data_x;
    end
    case (alu_func)
      FUNC_ADD: alu_out = dx.rs_data_x + alu_b;
      FUNC_SUB: alu_out = dx.rs_data_x - alu_b;
      FUNC_AND: alu_out = dx.rs_data_x & alu_b;
      FUNC_XOR: alu_out = dx.rs_data_x ^ alu_b;
    endcase
  end

  assign link_pc = dx.pc_x + PC_STEP;
  assign target  = link_pc + dx.imm_x;

  always_comb begin
    case (dx.result_sel_x)
      RES_IMM:  result = dx.imm_x;
      RES_LINK: result = link_pc;
      default:  result = alu_out;
    endcase
  end

  assign rs_zero = (dx.rs_data_x == '0);
  assign take    = dx.save_pc_x || (dx.branch_x && (rs_zero ^ dx.branch_ne_x));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ex_valid     <= 1'b0;
      ex_reg_write <= 1'b0;
      ex_mem_read  <= 1'b0;
      ex_mem_write <= 1'b0;
      branch_taken <= 1'b0;
      halt         <= 1'b0;
      err          <= 1'b0;
    end else if (!stall_m) begin
      ex_valid     <= live;
      ex_reg_write <= live && dx.reg_write_x;
      ex_mem_read  <= live && dx.mem_read_x;
      ex_mem_write <= live && dx.mem_write_x;
      branch_taken <= live && take;
      halt         <= live && dx.halt_x;
      // an illegal opcode travels as a nop, so it is not gated by live
      err          <= !branch_taken && dx.err_x;
    end
  end

  always_ff @(posedge clk) begin
    if (!stall_m) begin
      ex_result     <= result;
      ex_rd         <= dx.rd_x;
      ex_store_data <= dx.rt_data_x;
      branch_target <= target;
    end
  end

endmodule

//--- src/cpu_dx_top.sv
module cpu_dx_top import isa_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  word_t    instr,
  input  word_t    pc,
  input  logic     fetch_nop,
  output logic     hold,
  input  logic     stall_m,
  output logic     ex_valid,
  output word_t    ex_result,
  output reg_idx_t ex_rd,
  output logic     ex_reg_write,
  output logic     ex_mem_read,
  output logic     ex_mem_write,
  output word_t    ex_store_data,
  output logic     branch_taken,
  output word_t    branch_target,
  output logic     halt,
  output logic     err,
  input  logic     wb_en,
  input  reg_idx_t wb_rd,
  input  word_t    wb_data
);

  reg_idx_t ra;
  reg_idx_t rb;
  word_t    ra_data;
  word_t    rb_data;

  dx_if dx_bus ();

  decoder decoder_inst (
    .instr     (instr),
    .pc        (pc),
    .fetch_nop (fetch_nop),
    .stall_m   (stall_m),
    .ra        (ra),
    .rb        (rb),
    .ra_data   (ra_data),
    .rb_data   (rb_data),
    .dx        (dx_bus.decode),
    .hold      (hold)
  );

  reg_file reg_file_inst (
    .clk     (clk),
    .rst_n   (rst_n),
    .ra      (ra),
    .rb      (rb),
    .ra_data (ra_data),
    .rb_data (rb_data),
    .wb_en   (wb_en),
    .wb_rd   (wb_rd),
    .wb_data (wb_data)
  );

  // id_ex checks stall_m first, so hold acts as the hazard whenever it matters
  id_ex id_ex_inst (
    .clk     (clk),
    .rst_n   (rst_n),
    .dx      (dx_bus.register),
    .stall_m (stall_m),
    .hazard  (hold),
    .flush   (branch_taken)
  );

  execute execute_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .dx            (dx_bus.exec),
    .stall_m       (stall_m),
    .ex_valid      (ex_valid),
    .ex_result     (ex_result),
    .ex_rd         (ex_rd),
    .ex_reg_write  (ex_reg_write),
    .ex_mem_read   (ex_mem_read),
    .ex_mem_write  (ex_mem_write),
    .ex_store_data (ex_store_data),
    .branch_taken  (branch_taken),
    .branch_target (branch_target),
    .halt          (halt),
    .err           (err)
  );

endmodule

//--- bench/tb_clk_gen.sv
module tb_clk_gen #(
  parameter int PERIOD_NS = 100
) (
  output logic clk
);

  timeunit 1ns;
  timeprecision 1ns;

  initial begin
    clk = 1'b0;
    forever begin
      #(PERIOD_NS / 2) clk = ~clk;
    end
  end

endmodule

//--- bench/tb_cpu_dx.sv
module tb_cpu_dx import isa_pkg::*, pipe_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ns;

  localparam int    PROG_WORDS  = 128;
  localparam int    PROG_LEN    = 96;
  localparam word_t PROG_END    = word_t'(2 * PROG_LEN);
  localparam int    RUN_TIMEOUT = 5000;
  localparam word_t NOP_WORD    = {OP_NOP, 11'd0};

  typedef struct packed {
    logic     valid;
    logic     halt;
    logic     err;
    logic     reg_write;
    reg_idx_t rd;
    word_t    result;
    logic     mem_read;
    logic     mem_write;
    word_t    store_data;
    logic     taken;
    word_t    target;
  } expect_t;

  logic     clk;
  logic     rst_n;
  word_t    instr;
  word_t    pc;
  logic     fetch_nop;
  logic     hold;
  logic     stall_m;
  logic     ex_valid;
  word_t    ex_result;
  reg_idx_t ex_rd;
  logic     ex_reg_write;
  logic     ex_mem_read;
  logic     ex_mem_write;
  word_t    ex_store_data;
  logic     branch_taken;
  word_t    branch_target;
  logic     halt;
  logic     err;
  logic     wb_en;
  reg_idx_t wb_rd;
  word_t    wb_data;

  word_t   prog [PROG_WORDS];
  word_t   model_regs [8];
  expect_t exp_q [$];
  word_t   load_salt;
  logic    stall_enable;
  int      hazard_holds;

  tb_clk_gen #(.PERIOD_NS(100)) clk_gen_inst (.clk(clk));

  cpu_dx_top cpu_dx_top_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .instr         (instr),
    .pc            (pc),
    .fetch_nop     (fetch_nop),
    .hold          (hold),
    .stall_m       (stall_m),
    .ex_valid      (ex_valid),
    .ex_result     (ex_result),
    .ex_rd         (ex_rd),
    .ex_reg_write  (ex_reg_write),
    .ex_mem_read   (ex_mem_read),
    .ex_mem_write  (ex_mem_write),
    .ex_store_data (ex_store_data),
    .branch_taken  (branch_taken),
    .branch_target (branch_target),
    .halt          (halt),
    .err           (err),
    .wb_en         (wb_en),
    .wb_rd         (wb_rd),
    .wb_data       (wb_data)
  );

  task automatic check_word(input string name, input word_t exp, input word_t act);
    if (exp !== act) begin
      $display("[ERROR] %s expected %h actual %h", name, exp, act);
      $display("Testbench failed");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic check_reg(input string name, input reg_idx_t exp, input reg_idx_t act);
    if (exp !== act) begin
      $display("[ERROR] %s expected %0d actual %0d", name, exp, act);
      $display("Testbench failed");
      $fatal(1, "register index mismatch");
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      $display("[ERROR] %s expected %b actual %b", name, exp, act);
      $display("Testbench failed");
      $fatal(1, "flag mismatch");
    end
  endtask

  // memory contents seen by loads depend on the whole address
  function automatic word_t load_value(input word_t addr);
    return (addr * 16'h9e37) ^ load_salt;
  endfunction

  // steps the sequential model by one instruction and returns what execute must show
  function automatic expect_t ref_step(input word_t ins, input word_t cur_pc,
                                       output word_t next_pc);
    expect_t e;
    word_t   rs_val;
    word_t   rt_val;
    word_t   imm5;
    word_t   imm8;
    e       = '0;
    rs_val  = model_regs[ins[10:8]];
    rt_val  = model_regs[ins[7:5]];
    imm5    = {{11{ins[4]}}, ins[4:0]};
    imm8    = {{8{ins[7]}}, ins[7:0]};
    next_pc = cur_pc + PC_STEP;
    e.valid = 1'b1;
    case (ins[15:11])
      OP_NOP: e.valid = 1'b0;
      OP_HALT: e.halt = 1'b1;
      OP_ALU: begin
        e.reg_write = 1'b1;
        e.rd        = ins[4:2];
        case (ins[1:0])
          FUNC_ADD: e.result = rs_val + rt_val;
          FUNC_SUB: e.result = rs_val - rt_val;
          FUNC_AND: e.result = rs_val & rt_val;
          default:  e.result = rs_val ^ rt_val;
        endcase
      end
      OP_ADDI: begin
        e.reg_write = 1'b1;
        e.rd        = ins[7:5];
        e.result    = rs_val + imm5;
      end
      OP_LBI: begin
        e.reg_write = 1'b1;
        e.rd        = ins[10:8];
        e.result    = imm8;
      end
      OP_LD: begin
        e.reg_write = 1'b1;
        e.mem_read  = 1'b1;
        e.rd        = ins[7:5];
        e.result    = rs_val + imm5;
      end
      OP_ST: begin
        e.mem_write  = 1'b1;
        e.result     = rs_val + imm5;
        e.store_data = rt_val;
      end
      OP_BEQZ, OP_BNEZ: begin
        e.taken  = (ins[15:11] == OP_BNEZ) ? (rs_val != 16'd0) : (rs_val == 16'd0);
        e.target = cur_pc + PC_STEP + imm8;
      end
      OP_JAL: begin
        e.reg_write = 1'b1;
        e.rd        = 3'd7;
        e.result    = cur_pc + PC_STEP;
        e.taken     = 1'b1;
        e.target    = cur_pc + PC_STEP + imm8;
      end
      default: begin
        e.valid = 1'b0;
        e.err   = 1'b1;
      end
    endcase
    if (e.taken) begin
      next_pc = e.target;
    end
    if (e.reg_write) begin
      model_regs[e.rd] = e.mem_read ? load_value(e.result) : e.result;
    end
    return e;
  endfunction

  task automatic make_program();
    int       i;
    int       kind;
    reg_idx_t a;
    reg_idx_t b;
    reg_idx_t c;
    for (int j = 0; j < PROG_WORDS; j++) begin
      prog[j] = NOP_WORD;
    end
    prog[0] = {OP_LBI, 3'd1, 8'h35};
    i = 1;
    while (i < PROG_LEN - 1) begin
      kind = int'($urandom % 10);
      a    = reg_idx_t'($urandom);
      b    = reg_idx_t'($urandom);
      c    = reg_idx_t'($urandom);
      case (kind)
        0, 1, 2: prog[i] = {OP_ALU, a, b, c, func_t'($urandom)};
        3: prog[i] = {OP_ADDI, a, b, 5'($urandom)};
        4: prog[i] = {OP_LBI, a, 8'($urandom)};
        5: begin
          // a load whose result is used by the very next instruction
          prog[i] = {OP_LD, a, b, 5'($urandom)};
          if (i < PROG_LEN - 2) begin
            i++;
            prog[i] = {OP_ALU, b, c, a, FUNC_XOR};
          end
        end
        6: prog[i] = {OP_ST, a, b, 5'($urandom)};
        7: begin
          if (i < PROG_LEN - 8) begin
            prog[i] = {($urandom % 2 == 0) ? OP_BEQZ : OP_BNEZ, a,
                       8'(2 * (1 + $urandom % 4))};
          end
        end
        8: begin
          // the halt right after a jump must be squashed
          if (i < PROG_LEN - 8) begin
            prog[i] = {OP_JAL, 3'd0, 8'(2 * (1 + $urandom % 4))};
            i++;
            prog[i] = {OP_HALT, 11'd0};
          end
        end
        default: prog[i] = ($urandom % 2 == 0) ? {5'b11111, 11'($urandom)} : NOP_WORD;
      endcase
      i++;
    end
    prog[PROG_LEN - 1] = {OP_HALT, 11'd0};
  endtask

  task automatic build_expected();
    word_t   mpc;
    word_t   npc;
    expect_t e;
    int      steps;
    for (int r = 0; r < 8; r++) begin
      model_regs[r] = '0;
    end
    mpc   = '0;
    steps = 0;
    while (mpc < PROG_END && steps < 1000) begin
      e = ref_step(prog[mpc[7:1]], mpc, npc);
      if (e.valid || e.err) begin
        exp_q.push_back(e);
      end
      mpc = npc;
      steps++;
    end
  endtask

  task automatic expect_idle_outputs(input string name);
    check_bit({name, " ex_valid"}, 1'b0, ex_valid);
    check_bit({name, " ex_reg_write"}, 1'b0, ex_reg_write);
    check_bit({name, " ex_mem_read"}, 1'b0, ex_mem_read);
    check_bit({name, " ex_mem_write"}, 1'b0, ex_mem_write);
    check_bit({name, " branch_taken"}, 1'b0, branch_taken);
    check_bit({name, " halt"}, 1'b0, halt);
    check_bit({name, " err"}, 1'b0, err);
  endtask

  task automatic compare_retired(input expect_t e, input int n);
    string t;
    t = $sformatf("retire %0d", n);
    check_bit({t, " valid"}, e.valid, ex_valid);
    check_bit({t, " halt"}, e.halt, halt);
    check_bit({t, " err"}, e.err, err);
    check_bit({t, " reg_write"}, e.reg_write, ex_reg_write);
    check_bit({t, " mem_read"}, e.mem_read, ex_mem_read);
    check_bit({t, " mem_write"}, e.mem_write, ex_mem_write);
    check_bit({t, " branch_taken"}, e.taken, branch_taken);
    if (e.reg_write) begin
      check_reg({t, " rd"}, e.rd, ex_rd);
    end
    if (e.reg_write || e.mem_read || e.mem_write) begin
      check_word({t, " result"}, e.result, ex_result);
    end
    if (e.mem_write) begin
      check_word({t, " store_data"}, e.store_data, ex_store_data);
    end
    if (e.taken) begin
      check_word({t, " branch_target"}, e.target, branch_target);
    end
  endtask

  task automatic verify_frozen(input expect_t s);
    check_bit("stall ex_valid", s.valid, ex_valid);
    check_bit("stall halt", s.halt, halt);
    check_bit("stall err", s.err, err);
    check_bit("stall ex_reg_write", s.reg_write, ex_reg_write);
    check_reg("stall ex_rd", s.rd, ex_rd);
    check_word("stall ex_result", s.result, ex_result);
    check_bit("stall ex_mem_read", s.mem_read, ex_mem_read);
    check_bit("stall ex_mem_write", s.mem_write, ex_mem_write);
    check_word("stall ex_store_data", s.store_data, ex_store_data);
    check_bit("stall branch_taken", s.taken, branch_taken);
    check_word("stall branch_target", s.target, branch_target);
  endtask

  // fetch follows hold and the branch redirect seen before each rising edge
  initial begin
    word_t f_pc;
    logic  accept_seen;
    logic  flush_seen;
    word_t target_seen;
    f_pc        = '0;
    accept_seen = 1'b0;
    flush_seen  = 1'b0;
    target_seen = '0;
    instr       = NOP_WORD;
    pc          = '0;
    fetch_nop   = 1'b1;
    forever begin
      @(negedge clk);
      if (flush_seen) begin
        f_pc = target_seen;
      end else if (accept_seen) begin
        f_pc = f_pc + PC_STEP;
      end
      pc = f_pc;
      if (f_pc < PROG_END) begin
        instr     = prog[f_pc[7:1]];
        fetch_nop = 1'b0;
      end else begin
        instr     = NOP_WORD;
        fetch_nop = 1'b1;
      end
      #1;
      accept_seen = rst_n && !hold && !branch_taken;
      flush_seen  = rst_n && branch_taken && !stall_m;
      target_seen = branch_target;
      if (rst_n && hold && !stall_m) begin
        hazard_holds++;
      end
    end
  end

  // memory and writeback
  initial begin
    stall_m = 1'b0;
    wb_en   = 1'b0;
    wb_rd   = '0;
    wb_data = '0;
    forever begin
      @(negedge clk);
      stall_m = rst_n && stall_enable && ($urandom % 4 == 0);
      wb_en   = ex_reg_write && !stall_m;
      wb_rd   = ex_rd;
      wb_data = ex_mem_read ? load_value(ex_result) : ex_result;
    end
  end

  // every retired output is compared against the model queue
  initial begin
    expect_t e;
    expect_t snap;
    logic    prev_stall;
    int      n;
    prev_stall = 1'b0;
    n          = 0;
    forever begin
      @(negedge clk);
      #2;
      if (rst_n) begin
        if (prev_stall) begin
          verify_frozen(snap);
        end
        if (!ex_valid && !err) begin
          expect_idle_outputs("bubble");
        end else if (!stall_m) begin
          if (exp_q.size() == 0) begin
            $display("an output appeared after the program had retired");
            $display("Testbench failed");
            $fatal(1, "unexpected output");
          end else begin
            e = exp_q.pop_front();
            compare_retired(e, n);
            n++;
          end
        end
        snap = '{ex_valid, halt, err, ex_reg_write, ex_rd, ex_result, ex_mem_read,
                 ex_mem_write, ex_store_data, branch_taken, branch_target};
        prev_stall = stall_m;
      end
    end
  end

  initial begin
    int cycles;
    void'($urandom(55));
    rst_n        = 1'b0;
    stall_enable = 1'b0;
    hazard_holds = 0;
    load_salt    = word_t'($urandom);
    make_program();
    build_expected();
    $display("program expects %0d outputs", exp_q.size());
    repeat (4) @(posedge clk);
    @(negedge clk);
    expect_idle_outputs("reset");
    rst_n = 1'b1;
    // the first instruction is accepted at the next edge and shows one edge later
    @(negedge clk);
    expect_idle_outputs("first_latency");
    @(negedge clk);
    check_bit("first_latency ex_valid", 1'b1, ex_valid);
    stall_enable = 1'b1;
    cycles = 0;
    while (exp_q.size() > 0 && cycles < RUN_TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (exp_q.size() > 0) begin
      $display("timeout with %0d outputs never retired", exp_q.size());
      $display("Testbench failed");
      $fatal(1, "timeout");
    end else begin
      repeat (10) @(negedge clk);
      if (hazard_holds == 0) begin
        $display("hold never rose for a register hazard");
        $display("Testbench failed");
        $fatal(1, "no hazard seen");
      end else begin
        $display("Testbench passed");
        $finish;
      end
    end
  end

endmodule

//--- src.f
src/isa_pkg.sv
src/pipe_pkg.sv
src/dx_if.sv
src/decoder.sv
src/reg_file.sv
src/id_ex.sv
src/execute.sv
src/cpu_dx_top.sv
bench/tb_clk_gen.sv
bench/tb_cpu_dx.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal --top-module tb_cpu_dx -f src.f -o tb_sim

# the simulator exit status is ignored here, the log decides
./obj_dir/tb_sim > sim.log 2>&1 || true
cat sim.log

if grep -qx "Testbench passed" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi
